// File: common/rs_dispatch_if.sv
`timescale 1ns/1ps
`include "rs_params.svh"

interface rs_dispatch_if #(
    parameter type payload_t = logic
);
    import rs_pkg::*;

    logic                  valid;
    logic                  ready;     // Station has a free entry
    src_t                  src1;
    src_t                  src2;
    logic [`RS_TAG_W-1:0]  rd;
    logic [`RS_XLEN-1:0]   pc;
    logic [`RS_INUM_W-1:0] inst_num;  // Age for oldest-first issue
    payload_t              payload;   // Class specific control

    modport master (
        output valid, src1, src2, rd, pc, inst_num, payload,
        input  ready
    );

    modport slave (
        input  valid, src1, src2, rd, pc, inst_num, payload,
        output ready
    );

endinterface

// File: common/rs_params.svh
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// Datapath width of operands, pc and immediates
`define RS_XLEN 32

// Physical register tag width
`define RS_TAG_W 8

// Instruction sequence number, compared modulo 2^32
`define RS_INUM_W 32

// Entries per reservation station, 2, 4 or 8
`define RS_DEPTH 4

`endif

// File: common/rs_pkg.sv
`include "rs_params.svh"

package rs_pkg;

    typedef enum logic [1:0] {
        FU_ADD = 2'd0,  // Integer, loads and stores
        FU_MUL = 2'd1,
        FU_DIV = 2'd2,  // DIV and REM
        FU_BR  = 2'd3   // JAL, JALR and conditional branches
    } fu_class_t;

    typedef struct packed {
        logic [`RS_TAG_W-1:0] tag;
        logic                 ready;  // Value is valid
        logic [`RS_XLEN-1:0]  value;
    } src_t;

    typedef struct packed {
        logic [2:0]          funct3;
        logic [3:0]          alu_op;
        logic                mem_to_reg;
        logic                mem_read;
        logic                mem_write;
        logic                alu_src1;
        logic                alu_src2;
        logic [`RS_XLEN-1:0] imm;
        logic [7:0]          flags;  // Spare for the mul and div units
    } alu_payload_t;

    typedef struct packed {
        logic [2:0]          funct3;
        logic                jump;
        logic                branch;
        logic                pred_taken;  // Predictor bits ride along
        logic                pred_hit;
        logic [`RS_XLEN-1:0] imm;
    } br_payload_t;

    typedef struct packed {
        src_t                  src1;
        src_t                  src2;
        logic [`RS_TAG_W-1:0]  rd;
        logic [`RS_XLEN-1:0]   pc;
        logic [`RS_INUM_W-1:0] inst_num;
        fu_class_t             cls;
        logic [2:0]            funct3;
        logic [3:0]            alu_op;
        logic                  mem_to_reg;
        logic                  mem_read;
        logic                  mem_write;
        logic                  alu_src1;
        logic                  alu_src2;
        logic                  jump;
        logic                  branch;
        logic                  pred_taken;
        logic                  pred_hit;
        logic [`RS_XLEN-1:0]   imm;
    } uop_t;

    typedef struct packed {
        logic                 valid;
        logic [`RS_TAG_W-1:0] tag;
        logic [`RS_XLEN-1:0]  value;
    } cdb_t;

    // Captures a broadcast result into a waiting source
    function automatic src_t src_wake(src_t s, cdb_t c);
        src_t r;
        r = s;
        if (c.valid && !s.ready && s.tag == c.tag) begin
            r.ready = 1'b1;
            r.value = c.value;
        end
        return r;
    endfunction

endpackage

// File: hw/dispatch_router.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module dispatch_router (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [6:0]            opcode,
    input  logic [2:0]            funct3,
    input  logic [6:0]            funct7,
    input  logic [3:0]            alu_op,
    input  logic                  mem_to_reg,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  alu_src1,
    input  logic                  alu_src2,
    input  logic                  jump,
    input  logic                  branch,
    input  logic                  pred_taken,
    input  logic                  pred_hit,
    input  logic [`RS_TAG_W-1:0]  rs1_tag,
    input  logic                  rs1_ready,
    input  logic [`RS_XLEN-1:0]   rs1_value,
    input  logic [`RS_TAG_W-1:0]  rs2_tag,
    input  logic                  rs2_ready,
    input  logic [`RS_XLEN-1:0]   rs2_value,
    input  logic [`RS_TAG_W-1:0]  rd_tag,
    input  logic [`RS_XLEN-1:0]   imm,
    input  logic [`RS_XLEN-1:0]   pc,
    input  logic [`RS_INUM_W-1:0] inst_num,
    input  logic                  disp_valid,
    output logic                  disp_ready,
    input  rs_pkg::cdb_t          cdb,
    rs_dispatch_if.master         add_ch,
    rs_dispatch_if.master         mul_ch,
    rs_dispatch_if.master         div_ch,
    rs_dispatch_if.master         br_ch
);
    import rs_pkg::*;

    uop_t         in_uop;
    uop_t         stg;        // One-entry output stage
    logic         stg_valid;
    logic         is_bubble;
    logic         sel_ready;  // Ready of the station the stage points at
    logic         take;
    logic         load;
    alu_payload_t alu_pay;
    br_payload_t  br_pay;

    always_comb begin
        is_bubble = (opcode == 7'b0000000);
        in_uop.src1 = '{tag: rs1_tag, ready: rs1_ready, value: rs1_value};
        in_uop.src2 = '{tag: rs2_tag, ready: rs2_ready, value: rs2_value};
        in_uop.rd = rd_tag;
        in_uop.pc = pc;
        in_uop.inst_num = inst_num;
        in_uop.funct3 = funct3;
        in_uop.alu_op = alu_op;
        in_uop.mem_to_reg = mem_to_reg;
        in_uop.mem_read = mem_read;
        in_uop.mem_write = mem_write;
        in_uop.alu_src1 = alu_src1;
        in_uop.alu_src2 = alu_src2;
        in_uop.jump = jump;
        in_uop.branch = branch;
        in_uop.pred_taken = pred_taken;
        in_uop.pred_hit = pred_hit;
        in_uop.imm = imm;
        case (opcode)
            7'b1101111, 7'b1100111, 7'b1100011: in_uop.cls = FU_BR;
            7'b0110011: begin
                if (funct7 == 7'b0000001) begin
                    in_uop.cls = funct3[2] ? FU_DIV : FU_MUL;  // M extension
                end else begin
                    in_uop.cls = FU_ADD;
                end
            end
            default: in_uop.cls = FU_ADD;
        endcase
    end

    always_comb begin
        case (stg.cls)
            FU_MUL:  sel_ready = mul_ch.ready;
            FU_DIV:  sel_ready = div_ch.ready;
            FU_BR:   sel_ready = br_ch.ready;
            default: sel_ready = add_ch.ready;
        endcase
    end

    assign take = stg_valid && sel_ready;
    assign disp_ready = !stg_valid || take;
    assign load = disp_valid && disp_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stg_valid <= 1'b0;
        end else if (load) begin
            stg_valid <= !is_bubble;  // Bubbles are dropped here
        end else if (take) begin
            stg_valid <= 1'b0;
        end
    end

    // Sources keep snooping the broadcast while the stage waits
    always_ff @(posedge clk) begin
        if (load) begin
            stg <= in_uop;
            stg.src1 <= src_wake(in_uop.src1, cdb);
            stg.src2 <= src_wake(in_uop.src2, cdb);
        end else begin
            stg.src1 <= src_wake(stg.src1, cdb);
            stg.src2 <= src_wake(stg.src2, cdb);
        end
    end

    assign alu_pay = '{funct3: stg.funct3, alu_op: stg.alu_op, mem_to_reg: stg.mem_to_reg,
                       mem_read: stg.mem_read, mem_write: stg.mem_write,
                       alu_src1: stg.alu_src1, alu_src2: stg.alu_src2,
                       imm: stg.imm, flags: 8'h00};
    assign br_pay = '{funct3: stg.funct3, jump: stg.jump, branch: stg.branch,
                      pred_taken: stg.pred_taken, pred_hit: stg.pred_hit, imm: stg.imm};

    assign add_ch.valid = stg_valid && stg.cls == FU_ADD;
    assign add_ch.src1 = stg.src1;
    assign add_ch.src2 = stg.src2;
    assign add_ch.rd = stg.rd;
    assign add_ch.pc = stg.pc;
    assign add_ch.inst_num = stg.inst_num;
    assign add_ch.payload = alu_pay;

    assign mul_ch.valid = stg_valid && stg.cls == FU_MUL;
    assign mul_ch.src1 = stg.src1;
    assign mul_ch.src2 = stg.src2;
    assign mul_ch.rd = stg.rd;
    assign mul_ch.pc = stg.pc;
    assign mul_ch.inst_num = stg.inst_num;
    assign mul_ch.payload = alu_pay;

    assign div_ch.valid = stg_valid && stg.cls == FU_DIV;
    assign div_ch.src1 = stg.src1;
    assign div_ch.src2 = stg.src2;
    assign div_ch.rd = stg.rd;
    assign div_ch.pc = stg.pc;
    assign div_ch.inst_num = stg.inst_num;
    assign div_ch.payload = alu_pay;

    assign br_ch.valid = stg_valid && stg.cls == FU_BR;
    assign br_ch.src1 = stg.src1;
    assign br_ch.src2 = stg.src2;
    assign br_ch.rd = stg.rd;
    assign br_ch.pc = stg.pc;
    assign br_ch.inst_num = stg.inst_num;
    assign br_ch.payload = br_pay;

endmodule

// File: hw/rs_issue_top.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_issue_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [6:0]            opcode,
    input  logic [2:0]            funct3,
    input  logic [6:0]            funct7,
    input  logic [3:0]            alu_op,
    input  logic                  mem_to_reg,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  alu_src1,
    input  logic                  alu_src2,
    input  logic                  jump,
    input  logic                  branch,
    input  logic                  pred_taken,
    input  logic                  pred_hit,
    input  logic [`RS_TAG_W-1:0]  rs1_tag,
    input  logic                  rs1_ready,
    input  logic [`RS_XLEN-1:0]   rs1_value,
    input  logic [`RS_TAG_W-1:0]  rs2_tag,
    input  logic                  rs2_ready,
    input  logic [`RS_XLEN-1:0]   rs2_value,
    input  logic [`RS_TAG_W-1:0]  rd_tag,
    input  logic [`RS_XLEN-1:0]   imm,
    input  logic [`RS_XLEN-1:0]   pc,
    input  logic [`RS_INUM_W-1:0] inst_num,
    input  logic                  disp_valid,
    output logic                  disp_ready,
    input  logic                  cdb_valid,
    input  logic [`RS_TAG_W-1:0]  cdb_tag,
    input  logic [`RS_XLEN-1:0]   cdb_value,
    output logic                  add_issue_valid,
    output logic [`RS_XLEN-1:0]   add_issue_op1,
    output logic [`RS_XLEN-1:0]   add_issue_op2,
    output logic [`RS_TAG_W-1:0]  add_issue_rd,
    output logic [`RS_XLEN-1:0]   add_issue_pc,
    output logic [`RS_INUM_W-1:0] add_issue_inst_num,
    output logic [$bits(rs_pkg::alu_payload_t)-1:0] add_issue_payload,
    input  logic                  add_issue_ready,
    output logic                  mul_issue_valid,
    output logic [`RS_XLEN-1:0]   mul_issue_op1,
    output logic [`RS_XLEN-1:0]   mul_issue_op2,
    output logic [`RS_TAG_W-1:0]  mul_issue_rd,
    output logic [`RS_XLEN-1:0]   mul_issue_pc,
    output logic [`RS_INUM_W-1:0] mul_issue_inst_num,
    output logic [$bits(rs_pkg::alu_payload_t)-1:0] mul_issue_payload,
    input  logic                  mul_issue_ready,
    output logic                  div_issue_valid,
    output logic [`RS_XLEN-1:0]   div_issue_op1,
    output logic [`RS_XLEN-1:0]   div_issue_op2,
    output logic [`RS_TAG_W-1:0]  div_issue_rd,
    output logic [`RS_XLEN-1:0]   div_issue_pc,
    output logic [`RS_INUM_W-1:0] div_issue_inst_num,
    output logic [$bits(rs_pkg::alu_payload_t)-1:0] div_issue_payload,
    input  logic                  div_issue_ready,
    output logic                  br_issue_valid,
    output logic [`RS_XLEN-1:0]   br_issue_op1,
    output logic [`RS_XLEN-1:0]   br_issue_op2,
    output logic [`RS_TAG_W-1:0]  br_issue_rd,
    output logic [`RS_XLEN-1:0]   br_issue_pc,
    output logic [`RS_INUM_W-1:0] br_issue_inst_num,
    output logic [$bits(rs_pkg::br_payload_t)-1:0] br_issue_payload,
    input  logic                  br_issue_ready
);
    import rs_pkg::*;

    cdb_t cdb;  // Broadcast shared by router and stations

    assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

    rs_dispatch_if #(.payload_t(alu_payload_t)) add_ch ();
    rs_dispatch_if #(.payload_t(alu_payload_t)) mul_ch ();
    rs_dispatch_if #(.payload_t(alu_payload_t)) div_ch ();
    rs_dispatch_if #(.payload_t(br_payload_t))  br_ch ();

    // Port names match the top level one to one
    dispatch_router router_i (.*);

    reservation_station #(.payload_t(alu_payload_t)) add_rs (
        .clk(clk), .reset(reset), .ch(add_ch), .cdb(cdb),
        .issue_valid(add_issue_valid), .issue_op1(add_issue_op1),
        .issue_op2(add_issue_op2), .issue_rd(add_issue_rd), .issue_pc(add_issue_pc),
        .issue_inst_num(add_issue_inst_num), .issue_payload(add_issue_payload),
        .issue_ready(add_issue_ready)
    );

    reservation_station #(.payload_t(alu_payload_t)) mul_rs (
        .clk(clk), .reset(reset), .ch(mul_ch), .cdb(cdb),
        .issue_valid(mul_issue_valid), .issue_op1(mul_issue_op1),
        .issue_op2(mul_issue_op2), .issue_rd(mul_issue_rd), .issue_pc(mul_issue_pc),
        .issue_inst_num(mul_issue_inst_num), .issue_payload(mul_issue_payload),
        .issue_ready(mul_issue_ready)
    );

    reservation_station #(.payload_t(alu_payload_t)) div_rs (
        .clk(clk), .reset(reset), .ch(div_ch), .cdb(cdb),
        .issue_valid(div_issue_valid), .issue_op1(div_issue_op1),
        .issue_op2(div_issue_op2), .issue_rd(div_issue_rd), .issue_pc(div_issue_pc),
        .issue_inst_num(div_issue_inst_num), .issue_payload(div_issue_payload),
        .issue_ready(div_issue_ready)
    );

    reservation_station #(.payload_t(br_payload_t)) br_rs (
        .clk(clk), .reset(reset), .ch(br_ch), .cdb(cdb),
        .issue_valid(br_issue_valid), .issue_op1(br_issue_op1),
        .issue_op2(br_issue_op2), .issue_rd(br_issue_rd), .issue_pc(br_issue_pc),
        .issue_inst_num(br_issue_inst_num), .issue_payload(br_issue_payload),
        .issue_ready(br_issue_ready)
    );

endmodule

// File: rs/reservation_station.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module reservation_station #(
    parameter type payload_t = rs_pkg::alu_payload_t
) (
    input  logic                  clk,
    input  logic                  reset,
    rs_dispatch_if.slave          ch,
    input  rs_pkg::cdb_t          cdb,
    output logic                  issue_valid,
    output logic [`RS_XLEN-1:0]   issue_op1,
    output logic [`RS_XLEN-1:0]   issue_op2,
    output logic [`RS_TAG_W-1:0]  issue_rd,
    output logic [`RS_XLEN-1:0]   issue_pc,
    output logic [`RS_INUM_W-1:0] issue_inst_num,
    output payload_t              issue_payload,
    input  logic                  issue_ready
);
    import rs_pkg::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0]  ent_valid;
    src_t                  ent_src1 [`RS_DEPTH];
    src_t                  ent_src2 [`RS_DEPTH];
    logic [`RS_TAG_W-1:0]  ent_rd   [`RS_DEPTH];
    logic [`RS_XLEN-1:0]   ent_pc   [`RS_DEPTH];
    logic [`RS_INUM_W-1:0] ent_inum [`RS_DEPTH];
    payload_t              ent_pay  [`RS_DEPTH];

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] pick_idx;   // Oldest entry with both sources ready
    logic             pick_found;
    logic [IDX_W-1:0] held_idx;
    logic             held;       // Issue stalled, selection frozen
    logic [IDX_W-1:0] sel_idx;
    logic             alloc;
    logic             issue_fire;

    // Lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign ch.ready = ~&ent_valid;
    assign alloc = ch.valid && ch.ready;

    // Age compare on the difference so inst_num may wrap
    always_comb begin
        pick_found = 1'b0;
        pick_idx = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (ent_valid[i] && ent_src1[i].ready && ent_src2[i].ready) begin
                if (!pick_found || $signed(ent_inum[i] - ent_inum[pick_idx]) < 0) begin
                    pick_idx = IDX_W'(i);
                    pick_found = 1'b1;
                end
            end
        end
    end

    assign sel_idx = held ? held_idx : pick_idx;
    assign issue_valid = held || pick_found;
    assign issue_fire = issue_valid && issue_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ent_valid <= '0;
            held <= 1'b0;
            held_idx <= '0;
        end else begin
            if (alloc) begin
                ent_valid[free_idx] <= 1'b1;
            end
            if (issue_fire) begin
                ent_valid[sel_idx] <= 1'b0;  // Entry frees on handshake
                held <= 1'b0;
            end else if (issue_valid) begin
                held <= 1'b1;
                held_idx <= sel_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (alloc && free_idx == IDX_W'(i)) begin
                ent_src1[i] <= src_wake(ch.src1, cdb);  // Same-cycle broadcast
                ent_src2[i] <= src_wake(ch.src2, cdb);
                ent_rd[i] <= ch.rd;
                ent_pc[i] <= ch.pc;
                ent_inum[i] <= ch.inst_num;
                ent_pay[i] <= ch.payload;
            end else begin
                ent_src1[i] <= src_wake(ent_src1[i], cdb);
                ent_src2[i] <= src_wake(ent_src2[i], cdb);
            end
        end
    end

    assign issue_op1 = ent_src1[sel_idx].value;
    assign issue_op2 = ent_src2[sel_idx].value;
    assign issue_rd = ent_rd[sel_idx];
    assign issue_pc = ent_pc[sel_idx];
    assign issue_inst_num = ent_inum[sel_idx];
    assign issue_payload = ent_pay[sel_idx];

endmodule

// File: rs_issue.f
+incdir+common
common/rs_pkg.sv
common/rs_dispatch_if.sv
hw/dispatch_router.sv
rs/reservation_station.sv
hw/rs_issue_top.sv
sim/tb_clock.sv
sim/rs_issue_checker.sv
sim/rs_issue_tb.sv

// File: sim/rs_issue_checker.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_issue_checker #(
    parameter int PAY_W = 52
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         disp_valid,
    input  logic                         disp_ready,
    input  logic [6:0]                   opcode,
    input  logic [2:0]                   funct3,
    input  logic [6:0]                   funct7,
    input  logic [3:0]                   alu_op,
    input  logic [4:0]                   ctrl,      // mem_to_reg down to alu_src2
    input  logic [3:0]                   br_bits,   // jump, branch, pred_taken, pred_hit
    input  logic [`RS_TAG_W-1:0]         rs1_tag,
    input  logic                         rs1_ready,
    input  logic [`RS_XLEN-1:0]          rs1_value,
    input  logic [`RS_TAG_W-1:0]         rs2_tag,
    input  logic                         rs2_ready,
    input  logic [`RS_XLEN-1:0]          rs2_value,
    input  logic [`RS_TAG_W-1:0]         rd_tag,
    input  logic [`RS_XLEN-1:0]          imm,
    input  logic [`RS_XLEN-1:0]          pc,
    input  logic [`RS_INUM_W-1:0]        inst_num,
    input  logic                         cdb_valid,
    input  logic [`RS_TAG_W-1:0]         cdb_tag,
    input  logic [`RS_XLEN-1:0]          cdb_value,
    input  logic [3:0]                   iss_valid,  // Index 0 add, 1 mul, 2 div, 3 br
    input  logic [3:0]                   iss_ready,
    input  logic [3:0][`RS_XLEN-1:0]     iss_op1,
    input  logic [3:0][`RS_XLEN-1:0]     iss_op2,
    input  logic [3:0][`RS_TAG_W-1:0]    iss_rd,
    input  logic [3:0][`RS_XLEN-1:0]     iss_pc,
    input  logic [3:0][`RS_INUM_W-1:0]   iss_inum,
    input  logic [3:0][PAY_W-1:0]        iss_pay,
    output int                           outstanding,
    output int                           mismatches,
    output int                           failures
);

    localparam int MAXN = 512;
    localparam int SNAP_W = 3 * `RS_XLEN + `RS_TAG_W + `RS_INUM_W + PAY_W;

    bit                  seen [MAXN];
    bit                  done [MAXN];
    bit                  all_rdy [MAXN];  // Both sources ready at dispatch
    int                  cls [MAXN];      // 4 marks a bubble
    bit                  s1_ok [MAXN];
    bit                  s2_ok [MAXN];
    logic [`RS_TAG_W-1:0] s1_tag [MAXN];
    logic [`RS_TAG_W-1:0] s2_tag [MAXN];
    logic [`RS_XLEN-1:0] s1_val [MAXN];
    logic [`RS_XLEN-1:0] s2_val [MAXN];
    logic [`RS_TAG_W-1:0] exp_rd [MAXN];
    logic [`RS_XLEN-1:0] exp_pc [MAXN];
    logic [PAY_W-1:0]    exp_pay [MAXN];
    logic [`RS_INUM_W-1:0] last_inum [4];
    bit                  has_last [4];
    logic [3:0]          prev_v;
    logic [3:0]          prev_r;
    logic [SNAP_W-1:0]   prev_snap [4];

    function automatic int classify(logic [6:0] op, logic [2:0] f3, logic [6:0] f7);
        if (op == 7'b0000000) return 4;
        if (op == 7'b1101111 || op == 7'b1100111 || op == 7'b1100011) return 3;
        if (op == 7'b0110011 && f7 == 7'b0000001) return f3[2] ? 2 : 1;
        return 0;
    endfunction

    function automatic logic [SNAP_W-1:0] snap(int c);
        return {iss_op1[c], iss_op2[c], iss_rd[c], iss_pc[c], iss_inum[c], iss_pay[c]};
    endfunction

    task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_issue(int c);
        int n;
        n = int'(iss_inum[c]) % MAXN;
        if (!seen[n]) begin
            $display("Port %0d issued micro-op %0d that was never dispatched", c, n);
            failures++;
        end else if (done[n]) begin
            $display("Micro-op %0d was issued a second time", n);
            failures++;
        end else if (cls[n] == 4) begin
            $display("Bubble %0d was issued on port %0d", n, c);
            failures++;
        end else begin
            compare($sformatf("class of inst_num %0d", n), c, cls[n]);
            if (!s1_ok[n] || !s2_ok[n]) begin
                $display("Micro-op %0d issued before its sources were broadcast", n);
                failures++;
            end
            compare($sformatf("issue_op1[%0d]", c), iss_op1[c], s1_val[n]);
            compare($sformatf("issue_op2[%0d]", c), iss_op2[c], s2_val[n]);
            compare($sformatf("issue_rd[%0d]", c), iss_rd[c], exp_rd[n]);
            compare($sformatf("issue_pc[%0d]", c), iss_pc[c], exp_pc[n]);
            compare($sformatf("issue_payload[%0d]", c), iss_pay[c], exp_pay[n]);
            if (all_rdy[n]) begin
                if (has_last[c] && $signed(iss_inum[c] - last_inum[c]) <= 0) begin
                    $display("Port %0d issued %0d after younger %0d", c, n, last_inum[c]);
                    failures++;
                end
                last_inum[c] = iss_inum[c];
                has_last[c] = 1'b1;
            end
            done[n] = 1'b1;
            outstanding--;
        end
    endtask

    initial begin
        outstanding = 0;
        mismatches = 0;
        failures = 0;
        prev_v = '0;
        prev_r = '0;
    end

    always @(posedge clk) begin
        int n;
        if (reset) begin
            compare("issue_valid in reset", iss_valid, 4'h0);
            compare("disp_ready in reset", disp_ready, 1'b1);
            prev_v = '0;
        end else begin
            for (int c = 0; c < 4; c++) begin
                if (prev_v[c] && !prev_r[c]) begin  // Stalled outputs must hold
                    compare($sformatf("issue_valid[%0d] held", c), iss_valid[c], 1'b1);
                    if (snap(c) !== prev_snap[c]) begin
                        $display("Mismatch issue outputs[%0d] under stall: got %h expected %h",
                                 c, snap(c), prev_snap[c]);
                        mismatches++;
                    end
                end
            end
            if (disp_valid && disp_ready) begin
                n = int'(inst_num) % MAXN;
                seen[n] = 1'b1;
                done[n] = 1'b0;
                cls[n] = classify(opcode, funct3, funct7);
                all_rdy[n] = rs1_ready && rs2_ready;
                s1_ok[n] = rs1_ready;
                s2_ok[n] = rs2_ready;
                s1_tag[n] = rs1_tag;
                s2_tag[n] = rs2_tag;
                s1_val[n] = rs1_value;
                s2_val[n] = rs2_value;
                exp_rd[n] = rd_tag;
                exp_pc[n] = pc;
                if (cls[n] == 3) begin
                    exp_pay[n] = PAY_W'({funct3, br_bits, imm});
                end else begin
                    exp_pay[n] = {funct3, alu_op, ctrl, imm, 8'h00};
                end
                if (cls[n] != 4) outstanding++;
            end
            for (int c = 0; c < 4; c++) begin
                if (iss_valid[c] && iss_ready[c]) check_issue(c);
            end
            if (cdb_valid) begin
                for (int i = 0; i < MAXN; i++) begin
                    if (seen[i] && !done[i] && !s1_ok[i] && s1_tag[i] == cdb_tag) begin
                        s1_ok[i] = 1'b1;
                        s1_val[i] = cdb_value;
                    end
                    if (seen[i] && !done[i] && !s2_ok[i] && s2_tag[i] == cdb_tag) begin
                        s2_ok[i] = 1'b1;
                        s2_val[i] = cdb_value;
                    end
                end
            end
            for (int c = 0; c < 4; c++) prev_snap[c] = snap(c);
            prev_v = iss_valid;
            prev_r = iss_ready;
        end
    end

endmodule

// File: sim/rs_issue_tb.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_issue_tb;

    localparam int N_PHASE1 = 60;
    localparam int N_PHASE2 = 200;
    localparam int PERIOD = 100;
    localparam int PAY_W = $bits(rs_pkg::alu_payload_t);

    logic clk, reset;
    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    logic [3:0] alu_op;
    logic mem_to_reg, mem_read, mem_write, alu_src1, alu_src2;
    logic jump, branch, pred_taken, pred_hit;
    logic [`RS_TAG_W-1:0] rs1_tag, rs2_tag, rd_tag, cdb_tag;
    logic rs1_ready, rs2_ready, disp_valid, disp_ready, cdb_valid;
    logic [`RS_XLEN-1:0] rs1_value, rs2_value, imm, pc, cdb_value;
    logic [`RS_INUM_W-1:0] inst_num;
    logic add_issue_valid, mul_issue_valid, div_issue_valid, br_issue_valid;
    logic add_issue_ready, mul_issue_ready, div_issue_ready, br_issue_ready;
    logic [`RS_XLEN-1:0] add_issue_op1, mul_issue_op1, div_issue_op1, br_issue_op1;
    logic [`RS_XLEN-1:0] add_issue_op2, mul_issue_op2, div_issue_op2, br_issue_op2;
    logic [`RS_TAG_W-1:0] add_issue_rd, mul_issue_rd, div_issue_rd, br_issue_rd;
    logic [`RS_XLEN-1:0] add_issue_pc, mul_issue_pc, div_issue_pc, br_issue_pc;
    logic [`RS_INUM_W-1:0] add_issue_inst_num, mul_issue_inst_num;
    logic [`RS_INUM_W-1:0] div_issue_inst_num, br_issue_inst_num;
    logic [PAY_W-1:0] add_issue_payload, mul_issue_payload, div_issue_payload;
    logic [$bits(rs_pkg::br_payload_t)-1:0] br_issue_payload;
    int outstanding, mismatches, failures;

    logic [31:0] lfsr = 32'h0d5bdb42;
    logic [7:0]  tag_ctr = 8'h00;
    logic [7:0]  pending_q [$];  // Not-ready tags dispatched but not yet broadcast

    tb_clock #(.PERIOD(PERIOD)) clk_i (.clk(clk));

    rs_issue_top dut_i (.*);

    rs_issue_checker #(.PAY_W(PAY_W)) chk_i (
        .clk(clk), .reset(reset), .disp_valid(disp_valid), .disp_ready(disp_ready),
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .alu_op(alu_op),
        .ctrl({mem_to_reg, mem_read, mem_write, alu_src1, alu_src2}),
        .br_bits({jump, branch, pred_taken, pred_hit}),
        .rs1_tag(rs1_tag), .rs1_ready(rs1_ready), .rs1_value(rs1_value),
        .rs2_tag(rs2_tag), .rs2_ready(rs2_ready), .rs2_value(rs2_value),
        .rd_tag(rd_tag), .imm(imm), .pc(pc), .inst_num(inst_num),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .iss_valid({br_issue_valid, div_issue_valid, mul_issue_valid, add_issue_valid}),
        .iss_ready({br_issue_ready, div_issue_ready, mul_issue_ready, add_issue_ready}),
        .iss_op1({br_issue_op1, div_issue_op1, mul_issue_op1, add_issue_op1}),
        .iss_op2({br_issue_op2, div_issue_op2, mul_issue_op2, add_issue_op2}),
        .iss_rd({br_issue_rd, div_issue_rd, mul_issue_rd, add_issue_rd}),
        .iss_pc({br_issue_pc, div_issue_pc, mul_issue_pc, add_issue_pc}),
        .iss_inum({br_issue_inst_num, div_issue_inst_num, mul_issue_inst_num,
                   add_issue_inst_num}),
        .iss_pay({PAY_W'(br_issue_payload), div_issue_payload, mul_issue_payload,
                  add_issue_payload}),
        .outstanding(outstanding), .mismatches(mismatches), .failures(failures)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Tag 0 is never handed out, so ready sources use it
    function automatic logic [7:0] fresh_tag();
        logic clash;
        do begin
            tag_ctr = (tag_ctr == 8'hff) ? 8'h01 : tag_ctr + 8'h01;
            clash = 1'b0;
            foreach (pending_q[i]) if (pending_q[i] == tag_ctr) clash = 1'b1;
        end while (clash);
        return tag_ctr;
    endfunction

    task automatic send_uop(input bit may_wait);
        logic [6:0] ops [8];
        ops = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011,
                7'b1101111, 7'b1100111, 7'b1100011, 7'b0000000};
        opcode = ops[rand_bits(3)];
        funct3 = rand_bits(3);
        funct7 = rand_bits(1) ? 7'b0000001 : rand_bits(7);
        alu_op = rand_bits(4);
        {mem_to_reg, mem_read, mem_write, alu_src1, alu_src2} = rand_bits(5);
        {jump, branch, pred_taken, pred_hit} = rand_bits(4);
        rs1_ready = may_wait ? rand_bits(1) : 1'b1;
        rs2_ready = may_wait ? rand_bits(1) : 1'b1;
        rs1_tag = rs1_ready ? 8'h00 : fresh_tag();
        rs2_tag = rs2_ready ? 8'h00 : fresh_tag();
        rs1_value = rand_bits(32);
        rs2_value = rand_bits(32);
        rd_tag = rand_bits(8);
        imm = rand_bits(32);
        pc = {rand_bits(30), 2'b00};
        disp_valid = 1'b1;
        do @(posedge clk); while (!disp_ready);
        if (opcode != 7'b0000000 && !rs1_ready) pending_q.push_back(rs1_tag);
        if (opcode != 7'b0000000 && !rs2_ready) pending_q.push_back(rs2_tag);
        #1;
        disp_valid = 1'b0;
        inst_num = inst_num + 1;
    endtask

    initial begin
        {opcode, funct3, funct7, alu_op} = '0;
        {mem_to_reg, mem_read, mem_write, alu_src1, alu_src2} = '0;
        {jump, branch, pred_taken, pred_hit} = '0;
        {rs1_tag, rs1_ready, rs1_value, rs2_tag, rs2_ready, rs2_value} = '0;
        {rd_tag, imm, pc, inst_num, disp_valid} = '0;
        {cdb_valid, cdb_tag, cdb_value} = '0;
        {add_issue_ready, mul_issue_ready, div_issue_ready, br_issue_ready} = 4'hf;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < N_PHASE1; i++) send_uop(1'b0);
        for (int i = 0; i < N_PHASE2; i++) send_uop(1'b1);
        while (pending_q.size() != 0 || outstanding != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Broadcast one pending tag about half the cycles
    always @(posedge clk) begin
        int idx;
        #1;
        cdb_valid = 1'b0;
        if (!reset && pending_q.size() != 0 && rand_bits(1)) begin
            idx = int'(rand_bits(8)) % pending_q.size();
            cdb_tag = pending_q[idx];
            pending_q.delete(idx);
            cdb_value = rand_bits(32);
            cdb_valid = 1'b1;
        end
    end

    always @(posedge clk) begin
        #1;
        if (!reset) begin
            add_issue_ready = rand_bits(2) != 0;  // Low a quarter of the time
            mul_issue_ready = rand_bits(2) != 0;
            div_issue_ready = rand_bits(2) != 0;
            br_issue_ready = rand_bits(2) != 0;
        end
    end

    initial begin
        #(20 * (N_PHASE1 + N_PHASE2) * PERIOD);
        $display("Watchdog expired with %0d micro-ops still not issued", outstanding);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule
